//--- design/ext_harness.sv
// ####################
// External device subsystem, processor side left as ports
// ####################

`timescale 1ns/1ps

module ext_harness import ext_pkg::*; #(
  parameter int unsigned NumWords  = 128,
  parameter int unsigned FifoDepth = 4,
  parameter int unsigned CntMax    = 8
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Register bus to the copy engine
  input  logic       reg_valid_i,
  input  logic       reg_write_i,
  input  logic [7:0] reg_addr_i,
  input  word_t      reg_wdata_i,
  output logic       reg_ready_o,
  output word_t      reg_rdata_o,
  output logic       reg_error_o,
  // OBI host port to the memory
  input  logic       host_req_i,
  input  logic       host_we_i,
  input  addr_t      host_addr_i,
  input  word_t      host_wdata_i,
  input  logic [3:0] host_be_i,
  output logic       host_gnt_o,
  output word_t      host_rdata_o,
  output logic       host_rvalid_o,
  output logic       memcopy_intr_o,
  input  logic       gpio_i,
  output logic       gpio_o
);

  // Copy engine master to memory DMA port
  logic       dma_req;
  logic       dma_we;
  addr_t      dma_addr;
  word_t      dma_wdata;
  logic [3:0] dma_be;
  logic       dma_gnt;
  word_t      dma_rdata;
  logic       dma_rvalid;

  slow_memory #(
    .NumWords(NumWords)
  ) i_slow_memory (
    .clk_i,
    .rst_n_i,
    .host_req_i,
    .host_we_i,
    .host_addr_i,
    .host_wdata_i,
    .host_be_i,
    .host_gnt_o,
    .host_rdata_o,
    .host_rvalid_o,
    .dma_req_i   (dma_req),
    .dma_we_i    (dma_we),
    .dma_addr_i  (dma_addr),
    .dma_wdata_i (dma_wdata),
    .dma_be_i    (dma_be),
    .dma_gnt_o   (dma_gnt),
    .dma_rdata_o (dma_rdata),
    .dma_rvalid_o(dma_rvalid)
  );

  memcopy_periph #(
    .FifoDepth(FifoDepth)
  ) i_memcopy_periph (
    .clk_i,
    .rst_n_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_ready_o,
    .reg_rdata_o,
    .reg_error_o,
    .dma_req_o   (dma_req),
    .dma_we_o    (dma_we),
    .dma_addr_o  (dma_addr),
    .dma_wdata_o (dma_wdata),
    .dma_be_o    (dma_be),
    .dma_gnt_i   (dma_gnt),
    .dma_rdata_i (dma_rdata),
    .dma_rvalid_i(dma_rvalid),
    .memcopy_intr_o
  );

  gpio_cnt #(
    .CntMax(CntMax)
  ) i_gpio_cnt (
    .clk_i,
    .rst_n_i,
    .gpio_i,
    .gpio_o
  );

endmodule

//--- design/ext_pkg.sv
// ####################
// Shared widths, register map and response entry type
// Imported by the memory, the copy engine and the top level
// ####################

package ext_pkg;

  parameter int unsigned AddrWidth = 32;
  parameter int unsigned DataWidth = 32;

  // Byte address and data word on every bus
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] word_t;

  // Copy engine register offsets
  localparam logic [7:0] REG_SRC_PTR = 8'h00;
  localparam logic [7:0] REG_DST_PTR = 8'h04;
  localparam logic [7:0] REG_SIZE    = 8'h08;
  localparam logic [7:0] REG_STATUS  = 8'h0C;

  // Status register bits
  localparam int unsigned STATUS_DONE_BIT = 0;
  localparam int unsigned STATUS_BUSY_BIT = 1;

  // Pending read response, owner 0 is host and 1 is DMA
  typedef struct packed {
    logic  owner;
    word_t rdata;
  } rsp_entry_t;

endpackage

//--- design/gpio_cnt.sv
// ####################
// Rising edge counter on a GPIO pin
// Toggles the output pin every CntMax edges
// ####################

`timescale 1ns/1ps

module gpio_cnt #(
  parameter int unsigned CntMax = 8
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic gpio_i,
  output logic gpio_o
);

  localparam int unsigned CntW = (CntMax > 1) ? $clog2(CntMax) : 1;

  logic            prev_q;
  logic            out_q;
  logic [CntW-1:0] cnt_q;
  logic            rise;

  assign rise   = gpio_i & ~prev_q;
  assign gpio_o = out_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prev_q <= 1'b0;
      out_q  <= 1'b0;
      cnt_q  <= '0;
    end else begin
      prev_q <= gpio_i;
      if (rise) begin
        // Last edge of the period, restart the count
        if (cnt_q == CntW'(CntMax - 1)) begin
          cnt_q <= '0;
          out_q <= ~out_q;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

endmodule

//--- design/memcopy_periph.sv
// ####################
// Register-programmed copy engine with one OBI master port
// Writing a nonzero size starts a copy, interrupt marks the end
// ####################

`timescale 1ns/1ps

module memcopy_periph import ext_pkg::*; #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Register bus
  input  logic       reg_valid_i,
  input  logic       reg_write_i,
  input  logic [7:0] reg_addr_i,
  input  word_t      reg_wdata_i,
  output logic       reg_ready_o,
  output word_t      reg_rdata_o,
  output logic       reg_error_o,
  // OBI master port
  output logic       dma_req_o,
  output logic       dma_we_o,
  output addr_t      dma_addr_o,
  output word_t      dma_wdata_o,
  output logic [3:0] dma_be_o,
  input  logic       dma_gnt_i,
  input  word_t      dma_rdata_i,
  input  logic       dma_rvalid_i,
  output logic       memcopy_intr_o
);

  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  addr_t           src_ptr_q;
  addr_t           dst_ptr_q;
  word_t           size_q;
  logic            busy_q;
  logic            done_q;
  logic            intr_q;
  word_t           status;
  word_t           rd_issued_q;
  word_t           wr_issued_q;
  word_t           wr_done_q;
  logic [CntW-1:0] rd_inflight_q;
  logic            req_q;
  logic            we_q;
  addr_t           addr_q;
  word_t           wdata_q;
  logic            rsp_is_write_q;
  word_t           fifo_rdata;
  logic            fifo_empty;
  logic [CntW-1:0] fifo_count;
  logic            reg_wr;
  logic            start;
  logic            slot_free;
  logic            wr_go;
  logic            rd_go;
  logic            rd_rsp;
  logic            wr_rsp;
  logic            last_wr_rsp;

  assign reg_ready_o = reg_valid_i;

  always_comb begin
    status                  = '0;
    status[STATUS_DONE_BIT] = done_q;
    status[STATUS_BUSY_BIT] = busy_q;
  end

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    case (reg_addr_i)
      REG_SRC_PTR: reg_rdata_o = src_ptr_q;
      REG_DST_PTR: reg_rdata_o = dst_ptr_q;
      REG_SIZE:    reg_rdata_o = size_q;
      REG_STATUS:  reg_rdata_o = status;
      default:     reg_error_o = reg_valid_i;
    endcase
  end

  // Writes while busy are dropped silently
  assign reg_wr = reg_valid_i & reg_write_i & ~busy_q;
  assign start  = reg_wr & (reg_addr_i == REG_SIZE) & (reg_wdata_i != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_ptr_q <= '0;
      dst_ptr_q <= '0;
      size_q    <= '0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      intr_q    <= 1'b0;
    end else begin
      intr_q <= 1'b0;
      if (reg_wr) begin
        case (reg_addr_i)
          REG_SRC_PTR: src_ptr_q <= reg_wdata_i;
          REG_DST_PTR: dst_ptr_q <= reg_wdata_i;
          REG_SIZE: begin
            // Zero size completes at once
            size_q <= reg_wdata_i;
            busy_q <= start;
            done_q <= ~start;
            intr_q <= ~start;
          end
          default: begin
          end
        endcase
      end
      if (last_wr_rsp) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
        intr_q <= 1'b1;
      end
    end
  end

  // A new request is loaded once the current one is granted
  assign slot_free = ~req_q | dma_gnt_i;
  assign wr_go     = busy_q & ~fifo_empty;
  assign rd_go     = busy_q & ~wr_go & (rd_issued_q != size_q) &
                     ((32'(fifo_count) + 32'(rd_inflight_q)) < FifoDepth);

  // Memory answers exactly one cycle after the grant
  assign rd_rsp      = dma_rvalid_i & ~rsp_is_write_q;
  assign wr_rsp      = dma_rvalid_i & rsp_is_write_q;
  assign last_wr_rsp = wr_rsp & ((wr_done_q + 32'd1) == size_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q          <= 1'b0;
      we_q           <= 1'b0;
      rsp_is_write_q <= 1'b0;
      rd_issued_q    <= '0;
      wr_issued_q    <= '0;
      wr_done_q      <= '0;
      rd_inflight_q  <= '0;
    end else begin
      if (slot_free) begin
        req_q <= wr_go | rd_go;
        we_q  <= wr_go;
      end
      if (dma_gnt_i) begin
        rsp_is_write_q <= we_q;
      end
      if (start) begin
        rd_issued_q   <= '0;
        wr_issued_q   <= '0;
        wr_done_q     <= '0;
        rd_inflight_q <= '0;
      end else begin
        if (slot_free && wr_go) begin
          wr_issued_q <= wr_issued_q + 32'd1;
        end
        if (slot_free && rd_go) begin
          rd_issued_q <= rd_issued_q + 32'd1;
        end
        if (wr_rsp) begin
          wr_done_q <= wr_done_q + 32'd1;
        end
        rd_inflight_q <= rd_inflight_q + CntW'(slot_free & rd_go) - CntW'(rd_rsp);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (slot_free && wr_go) begin
      addr_q  <= dst_ptr_q + {wr_issued_q[29:0], 2'b00};
      wdata_q <= fifo_rdata;
    end else if (slot_free && rd_go) begin
      addr_q <= src_ptr_q + {rd_issued_q[29:0], 2'b00};
    end
  end

  sync_fifo #(
    .payload_t(word_t),
    .Depth    (FifoDepth)
  ) i_word_fifo (
    .clk_i,
    .rst_n_i,
    .push_i (rd_rsp),
    .data_i (dma_rdata_i),
    .pop_i  (slot_free & wr_go),
    .data_o (fifo_rdata),
    .full_o (),
    .empty_o(fifo_empty),
    .count_o(fifo_count)
  );

  assign dma_req_o      = req_q;
  assign dma_we_o       = we_q;
  assign dma_addr_o     = addr_q;
  assign dma_wdata_o    = wdata_q;
  assign dma_be_o       = 4'hF;
  assign memcopy_intr_o = intr_q;

endmodule

//--- design/slow_memory.sv
// ####################
// Dual-port OBI memory with random grant stalls
// Host port has priority over the DMA port
// ####################

`timescale 1ns/1ps

module slow_memory import ext_pkg::*; #(
  parameter int unsigned NumWords = 128
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Host port
  input  logic       host_req_i,
  input  logic       host_we_i,
  input  addr_t      host_addr_i,
  input  word_t      host_wdata_i,
  input  logic [3:0] host_be_i,
  output logic       host_gnt_o,
  output word_t      host_rdata_o,
  output logic       host_rvalid_o,
  // DMA port
  input  logic       dma_req_i,
  input  logic       dma_we_i,
  input  addr_t      dma_addr_i,
  input  word_t      dma_wdata_i,
  input  logic [3:0] dma_be_i,
  output logic       dma_gnt_o,
  output word_t      dma_rdata_o,
  output logic       dma_rvalid_o
);

  localparam int unsigned IdxW     = $clog2(NumWords);
  localparam int unsigned RspDepth = 2;

  word_t           mem_q [NumWords];
  logic [7:0]      lfsr_q;
  logic [1:0]      stall_cnt_q;
  logic            any_req;
  logic            stall;
  logic            grant;
  logic            sel_dma;
  logic            sel_we;
  addr_t           sel_addr;
  word_t           sel_wdata;
  logic [3:0]      sel_be;
  logic [IdxW-1:0] idx;
  rsp_entry_t      rsp_in;
  rsp_entry_t      rsp_head;
  logic            rsp_full;
  logic            rsp_empty;

  // Random stall, never more than three cycles in a row
  assign any_req = host_req_i | dma_req_i;
  assign stall   = lfsr_q[0] & (stall_cnt_q != 2'd3);
  assign grant   = any_req & ~stall & ~rsp_full;

  assign sel_dma    = ~host_req_i;
  assign host_gnt_o = grant & host_req_i;
  assign dma_gnt_o  = grant & sel_dma;

  assign sel_we    = sel_dma ? dma_we_i    : host_we_i;
  assign sel_addr  = sel_dma ? dma_addr_i  : host_addr_i;
  assign sel_wdata = sel_dma ? dma_wdata_i : host_wdata_i;
  assign sel_be    = sel_dma ? dma_be_i    : host_be_i;
  assign idx       = sel_addr[IdxW+1:2];

  // 8-bit Fibonacci LFSR, taps 8 6 5 4
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lfsr_q      <= 8'hA5;
      stall_cnt_q <= '0;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      if (grant || !any_req) begin
        stall_cnt_q <= '0;
      end else if (stall) begin
        stall_cnt_q <= stall_cnt_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant && sel_we) begin
      for (int b = 0; b < 4; b++) begin
        if (sel_be[b]) begin
          mem_q[idx][8*b +: 8] <= sel_wdata[8*b +: 8];
        end
      end
    end
  end

  // One entry per grant, tagged with the owning port
  assign rsp_in = '{owner: sel_dma, rdata: mem_q[idx]};

  sync_fifo #(
    .payload_t(rsp_entry_t),
    .Depth    (RspDepth)
  ) i_rsp_fifo (
    .clk_i,
    .rst_n_i,
    .push_i (grant),
    .data_i (rsp_in),
    .pop_i  (~rsp_empty),
    .data_o (rsp_head),
    .full_o (rsp_full),
    .empty_o(rsp_empty),
    .count_o()
  );

  // Head entry is popped the cycle after its grant
  assign host_rvalid_o = ~rsp_empty & ~rsp_head.owner;
  assign dma_rvalid_o  = ~rsp_empty & rsp_head.owner;
  assign host_rdata_o  = rsp_head.rdata;
  assign dma_rdata_o   = rsp_head.rdata;

endmodule

//--- design/sync_fifo.sv
// ####################
// Synchronous FIFO with a typed payload, first word fall through
// ####################

`timescale 1ns/1ps

module sync_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned Depth     = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         push_i,
  input  payload_t                     data_i,
  input  logic                         pop_i,
  output payload_t                     data_o,
  output logic                         full_o,
  output logic                         empty_o,
  output logic [$clog2(Depth+1)-1:0]   count_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];

  // Overflow and underflow requests are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

endmodule

//--- sim.f
design/ext_pkg.sv
design/sync_fifo.sv
design/slow_memory.sv
design/memcopy_periph.sv
design/gpio_cnt.sv
design/ext_harness.sv
verif/tb_clk_gen.sv
verif/ext_harness_assertions.sv
verif/tb_ext_harness.sv

//--- verif/ext_harness_assertions.sv
// ####################
// Protocol assertions, bound into the subsystem top level
// ####################

`timescale 1ns/1ps

module ext_harness_assertions (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        reg_valid_i,
  input logic        reg_ready_i,
  input logic        host_gnt_i,
  input logic        host_rvalid_i,
  input logic        dma_req_i,
  input logic        dma_we_i,
  input logic [31:0] dma_addr_i,
  input logic [31:0] dma_wdata_i,
  input logic [3:0]  dma_be_i,
  input logic        dma_gnt_i,
  input logic        dma_rvalid_i,
  input logic        intr_i
);

  // Read back by the testbench top
  int fail_cnt = 0;

  // Register bus answers in the same cycle
  ready_follows_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_ready_i == reg_valid_i)
    else begin
      fail_cnt++;
      $error("Register ready does not follow valid");
    end

  // Master holds the request until granted
  dma_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma_req_i && !dma_gnt_i |=> dma_req_i && $stable(dma_we_i) && $stable(dma_addr_i)
      && $stable(dma_wdata_i) && $stable(dma_be_i))
    else begin
      fail_cnt++;
      $error("DMA request changed before its grant");
    end

  // Response comes one cycle after its grant
  host_rsp_granted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rvalid_i |-> $past(host_gnt_i))
    else begin
      fail_cnt++;
      $error("Host rvalid without an outstanding grant");
    end

  dma_rsp_granted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma_rvalid_i |-> $past(dma_gnt_i))
    else begin
      fail_cnt++;
      $error("DMA rvalid without an outstanding grant");
    end

  intr_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    intr_i |=> !intr_i)
    else begin
      fail_cnt++;
      $error("Copy interrupt longer than one cycle");
    end

endmodule

bind ext_harness ext_harness_assertions i_ext_harness_assertions (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .reg_valid_i  (reg_valid_i),
  .reg_ready_i  (reg_ready_o),
  .host_gnt_i   (host_gnt_o),
  .host_rvalid_i(host_rvalid_o),
  .dma_req_i    (dma_req),
  .dma_we_i     (dma_we),
  .dma_addr_i   (dma_addr),
  .dma_wdata_i  (dma_wdata),
  .dma_be_i     (dma_be),
  .dma_gnt_i    (dma_gnt),
  .dma_rvalid_i (dma_rvalid),
  .intr_i       (memcopy_intr_o)
);

//--- verif/tb_clk_gen.sv
// ####################
// Testbench clock and reset
// Reset is released on a falling edge
// ####################

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real         Period      = 10.0,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(Period / 2.0) clk_o = ~clk_o;
    end
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- verif/tb_ext_harness.sv
// ####################
// Testbench top, plays the core on the register bus and host port
// Memory data is checked against a model of all host writes
// ####################

`timescale 1ns/1ps

module tb_ext_harness import ext_pkg::*; ();

  localparam int unsigned NumWords    = 128;
  localparam int unsigned Timeout     = 200;
  localparam int unsigned CopyTimeout = 3000;
  localparam int unsigned IntrTimeout = 2;

  logic        clk;
  logic        rst_n;
  logic        reg_valid;
  logic        reg_write;
  logic [7:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic        reg_ready;
  logic [31:0] reg_rdata;
  logic        reg_error;
  logic        host_req;
  logic        host_we;
  logic [31:0] host_addr;
  logic [31:0] host_wdata;
  logic [3:0]  host_be;
  logic        host_gnt;
  logic [31:0] host_rdata;
  logic        host_rvalid;
  logic        memcopy_intr;
  logic        gpio_in;
  logic        gpio_out;

  logic [31:0] model [NumWords];
  logic [31:0] lfsr_state;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          intr_count = 0;

  tb_clk_gen #(
    .Period     (10.0),
    .ResetCycles(4)
  ) i_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  ext_harness #(
    .NumWords (NumWords),
    .FifoDepth(4),
    .CntMax   (8)
  ) i_ext_harness (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_write),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_ready_o   (reg_ready),
    .reg_rdata_o   (reg_rdata),
    .reg_error_o   (reg_error),
    .host_req_i    (host_req),
    .host_we_i     (host_we),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_be_i     (host_be),
    .host_gnt_o    (host_gnt),
    .host_rdata_o  (host_rdata),
    .host_rvalid_o (host_rvalid),
    .memcopy_intr_o(memcopy_intr),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out)
  );

  // Interrupt pulses, counted mid-cycle
  always @(negedge clk) begin
    if (rst_n && memcopy_intr) begin
      intr_count++;
    end
  end

  function automatic int total_errors();
    return errors + i_ext_harness.i_ext_harness_assertions.fail_cnt;
  endfunction

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_random(input int nbits, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timed out waiting for %s", what);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    if (total_errors() > errors_before) begin
      failed_tests++;
      $display("Test %0d %s: FAIL", tests, name);
    end else begin
      $display("Test %0d %s: PASS", tests, name);
    end
  endtask

  // One OBI transfer on the host port, request held until granted
  task automatic obi_transfer(input logic we, input int unsigned word_idx,
                              input logic [31:0] wdata, input logic [3:0] be,
                              output logic [31:0] rdata);
    int unsigned n;
    n = 0;
    rdata = 'x;
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = word_idx << 2;
    host_wdata = wdata;
    host_be    = be;
    #1;
    while (!host_gnt && n < Timeout) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!host_gnt) begin
      report_timeout("host grant");
      host_req = 1'b0;
      return;
    end
    @(negedge clk);
    host_req = 1'b0;
    #1;
    n = 0;
    while (!host_rvalid && n < Timeout) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!host_rvalid) begin
      report_timeout("host rvalid");
    end else begin
      rdata = host_rdata;
    end
  endtask

  task automatic host_write(input int unsigned word_idx, input logic [31:0] wdata,
                            input logic [3:0] be);
    logic [31:0] unused;
    obi_transfer(1'b1, word_idx, wdata, be, unused);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        model[word_idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic host_read_check(input int unsigned word_idx);
    logic [31:0] rd;
    obi_transfer(1'b0, word_idx, '0, 4'hF, rd);
    check_value("host_rdata_o", model[word_idx], rd);
  endtask

  task automatic reg_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    #1;
    rdata = reg_rdata;
    err   = reg_error;
    @(negedge clk);
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic reg_write_word(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    logic        err;
    reg_access(1'b1, addr, wdata, unused, err);
  endtask

  task automatic reg_read_check(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b0, addr, '0, rd, err);
    check_value("reg_rdata_o", exp, rd);
  endtask

  task automatic wait_intr(input int target, input int unsigned limit);
    int unsigned n;
    n = 0;
    while (intr_count < target && n < limit) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (intr_count < target) begin
      report_timeout("the copy interrupt");
    end
  endtask

  task automatic gpio_edges(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      gpio_in = 1'b1;
      @(negedge clk);
      gpio_in = 1'b0;
    end
  endtask

  initial begin
    logic [31:0] v;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rd;
    logic        err;
    int          base_intr;
    int unsigned ops;
    int          e0;

    lfsr_state = 32'h780d;
    reg_valid  = 1'b0;
    reg_write  = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_be    = '0;
    gpio_in    = 1'b0;

    ops = 0;
    while (!rst_n && ops < Timeout) begin
      @(negedge clk);
      ops++;
    end
    if (!rst_n) begin
      report_timeout("reset release");
    end

    // Fill, then random partial writes anywhere
    e0 = total_errors();
    for (int i = 0; i < NumWords; i++) begin
      next_random(32, v);
      host_write(i, v, 4'hF);
    end
    for (int i = 0; i < 32; i++) begin
      next_random(7, a);
      next_random(32, v);
      next_random(4, b);
      host_write(a, v, b[3:0]);
    end
    for (int i = 0; i < NumWords; i++) begin
      host_read_check(i);
    end
    finish_test("host write and read back", e0);

    // Zero size, register read back, bad offset, write while busy
    // Done is still clear from reset here
    e0 = total_errors();
    reg_write_word(REG_SRC_PTR, 32'h180);
    reg_write_word(REG_DST_PTR, 32'h1C0);
    base_intr = intr_count;
    reg_write_word(REG_SIZE, 32'd0);
    wait_intr(base_intr + 1, IntrTimeout);
    reg_read_check(REG_STATUS, 32'h1);
    reg_read_check(REG_SRC_PTR, 32'h180);
    reg_read_check(REG_DST_PTR, 32'h1C0);
    reg_access(1'b0, 8'h10, '0, rd, err);
    check_value("reg_error_o", 32'h1, {31'd0, err});
    base_intr = intr_count;
    reg_write_word(REG_SIZE, 32'd4);
    reg_read_check(REG_STATUS, 32'h2);
    reg_write_word(REG_SRC_PTR, 32'h000);
    reg_read_check(REG_SRC_PTR, 32'h180);
    wait_intr(base_intr + 1, CopyTimeout);
    reg_read_check(REG_STATUS, 32'h1);
    for (int i = 0; i < 4; i++) begin
      model[112 + i] = model[96 + i];
      host_read_check(112 + i);
    end
    finish_test("register access", e0);

    // Words 0..15 to words 64..79
    e0 = total_errors();
    base_intr = intr_count;
    reg_write_word(REG_SRC_PTR, 32'h000);
    reg_write_word(REG_DST_PTR, 32'h100);
    reg_write_word(REG_SIZE, 32'd16);
    wait_intr(base_intr + 1, CopyTimeout);
    reg_read_check(REG_STATUS, 32'h1);
    for (int i = 0; i < 16; i++) begin
      model[64 + i] = model[i];
      host_read_check(64 + i);
    end
    finish_test("copy of 16 words", e0);

    // Words 16..31 to 80..95, host traffic stays in words 32..63
    e0 = total_errors();
    base_intr = intr_count;
    reg_write_word(REG_SRC_PTR, 32'h040);
    reg_write_word(REG_DST_PTR, 32'h140);
    reg_write_word(REG_SIZE, 32'd16);
    ops = 0;
    while (intr_count == base_intr && ops < 400) begin
      next_random(5, a);
      next_random(1, b);
      if (b[0]) begin
        next_random(32, v);
        host_write(32 + a, v, 4'hF);
      end else begin
        host_read_check(32 + a);
      end
      ops++;
    end
    wait_intr(base_intr + 1, CopyTimeout);
    reg_read_check(REG_STATUS, 32'h1);
    for (int i = 0; i < 16; i++) begin
      model[80 + i] = model[16 + i];
      host_read_check(80 + i);
    end
    finish_test("copy under host traffic", e0);

    // Output toggles on every 8th rising edge
    e0 = total_errors();
    gpio_edges(8);
    check_value("gpio_o", 32'h1, {31'd0, gpio_out});
    gpio_edges(7);
    check_value("gpio_o", 32'h1, {31'd0, gpio_out});
    gpio_edges(1);
    check_value("gpio_o", 32'h0, {31'd0, gpio_out});
    finish_test("gpio edge counter", e0);

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
